// ==== per2axi.f ====
+incdir+testbench
hdl/per2axi_pkg.sv
hdl/per2axi_req_channel.sv
hdl/per2axi_res_channel.sv
hdl/per2axi_busy_unit.sv
hdl/per2axi.sv
testbench/tb_per2axi.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the per2axi testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f per2axi.f --top-module tb_per2axi \
   --Mdir obj_dir -o tb_per2axi

./obj_dir/tb_per2axi > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
   echo "per2axi: simulation passed"
else
   echo "per2axi: simulation failed"
   exit 1
fi

// ==== testbench/tb_per2axi_model.svh ====
/*
 * Testbench model for the bridge
 * LCG, reference mappings for lane, strobe, size, ID and atomics, AXI slave queues
 */

`ifndef TB_PER2AXI_MODEL_SVH
`define TB_PER2AXI_MODEL_SVH

// Beat that the slave returns once its due cycle is reached
typedef struct packed {
   logic [2:0]  id;
   logic [63:0] data;
   logic [31:0] due;
} slave_beat_t;

localparam logic [63:0] RD_MULT = 64'h9E37_79B9_7F4A_7C15;

logic [31:0] lcg_state = 32'd98;
slave_beat_t r_q[$];
slave_beat_t b_q[$];

// High half swapped down, the low LCG bits cycle too fast
function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return {lcg_state[15:0], lcg_state[31:16]};
endfunction

function automatic logic [2:0] ref_bin_id(logic [4:0] id);
   for (int i = 4; i >= 0; i--) begin
      if (id[i]) begin
         return 3'(i);
      end
   end
   return 3'd0;
endfunction

function automatic logic [2:0] ref_size(logic [3:0] be);
   if (be == 4'b1111) begin
      return 3'd2;
   end
   if (be == 4'b0011 || be == 4'b0110 || be == 4'b1100) begin
      return 3'd1;
   end
   return 3'd0;
endfunction

// Result is {inverted data, AR lock, AW lock, AW atop}
function automatic logic [8:0] ref_atop(logic [5:0] atop);
   if (!atop[5]) begin
      return 9'h0;
   end
   case (atop[4:0])
      per2axi_pkg::AMO_LR:   return 9'b010_000000;
      per2axi_pkg::AMO_SC:   return 9'b001_000000;
      per2axi_pkg::AMO_SWAP: return {3'b000, per2axi_pkg::ATOP_SWAP};
      per2axi_pkg::AMO_ADD:  return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_ADD};
      per2axi_pkg::AMO_XOR:  return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_XOR};
      per2axi_pkg::AMO_AND:  return {3'b100, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_CLR};
      per2axi_pkg::AMO_OR:   return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_SET};
      per2axi_pkg::AMO_MIN:  return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_SMIN};
      per2axi_pkg::AMO_MAX:  return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_SMAX};
      per2axi_pkg::AMO_MINU: return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_UMIN};
      per2axi_pkg::AMO_MAXU: return {3'b000, per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_UMAX};
      default:               return 9'h0;
   endcase
endfunction

function automatic bit returns_data(logic [5:0] atop);
   return (atop != 6'h0) && (atop[5:3] != per2axi_pkg::ATOP_STORE);
endfunction

function automatic per2axi_pkg::axi_w_t ref_wbeat(logic [31:0] add, logic [31:0] wdata,
                                                  logic [3:0] be, logic inv);
   per2axi_pkg::axi_w_t wb;
   logic [31:0]         d;
   d       = inv ? ~wdata : wdata;
   wb.last = 1'b1;
   wb.data = add[2] ? {d, 32'h0} : {32'h0, d};
   wb.strb = add[2] ? {be, 4'h0} : {4'h0, be};
   return wb;
endfunction

function automatic logic [63:0] slave_rdata(logic [31:0] add);
   return 64'(add) * RD_MULT;
endfunction

function automatic logic [31:0] lane_of(logic [63:0] data, logic [31:0] add);
   return add[2] ? data[63:32] : data[31:0];
endfunction

task automatic queue_read_beat(logic [2:0] id, logic [63:0] data);
   slave_beat_t bt;
   bt.id   = id;
   bt.data = data;
   bt.due  = 32'(cycle + 1 + int'(lcg_next() % 6));
   r_q.push_back(bt);
endtask

task automatic queue_write_resp(logic [2:0] id);
   slave_beat_t bt;
   bt.id   = id;
   bt.data = 64'h0;
   bt.due  = 32'(cycle + 1 + int'(lcg_next() % 6));
   b_q.push_back(bt);
endtask

`endif

// ==== testbench/tb_per2axi.sv ====
/*
 * Testbench for the interconnect to AXI4 bridge
 * Random requests, AXI slave model with delays, response and busy checks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_per2axi;

   localparam int NB_CORES       = 4;
   localparam int PER_ID_WIDTH   = 5;
   localparam int AXI_ID_WIDTH   = 3;
   localparam int AXI_USER_WIDTH = 6;
   localparam int NUM_TRANS      = 400;
   localparam int TIMEOUT        = 40000;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  per_req;
   per2axi_pkg::per_req_t per_req_s;
   logic [4:0]            per_id;
   logic                  per_gnt;
   logic                  resp_valid;
   per2axi_pkg::per_resp_t resp;
   logic [4:0]            resp_id;
   logic [3:0][5:0]       user_tab;
   logic                  aw_valid;
   per2axi_pkg::axi_ax_t  aw;
   logic [2:0]            aw_id;
   logic [5:0]            aw_user;
   logic                  aw_ready;
   logic                  w_valid;
   per2axi_pkg::axi_w_t   w;
   logic                  w_ready;
   logic                  ar_valid;
   per2axi_pkg::axi_ax_t  ar;
   logic [2:0]            ar_id;
   logic [5:0]            ar_user;
   logic                  ar_ready;
   logic                  r_valid;
   logic [63:0]           r_data;
   logic [2:0]            r_id;
   logic                  r_ready;
   logic                  b_valid;
   logic [2:0]            b_id;
   logic                  b_ready;
   logic                  busy;

   // Model state, indexed by binary AXI ID
   int          cycle = 0;
   int          issued = 0;
   int          done_cnt = 0;
   int          outstanding = 0;
   int          value_errs = 0;
   int          proto_errs = 0;
   int          timeouts = 0;
   bit          run = 1'b0;
   bit          req_pending = 1'b0;
   bit [7:0]    resp_left = '0;
   bit [7:0]    is_atop_rd = '0;
   int          beats_left [8];
   int          resp_due [8];
   logic [31:0] exp_rdata [8];

`include "tb_per2axi_model.svh"

   always #20 clk = ~clk;

   per2axi #(
      .NB_CORES       (NB_CORES),
      .PER_ID_WIDTH   (PER_ID_WIDTH),
      .AXI_ID_WIDTH   (AXI_ID_WIDTH),
      .AXI_USER_WIDTH (AXI_USER_WIDTH)
   ) per2axi_inst (
      .clk_i               (clk),
      .rst_n_i             (rst_n),
      .per_slave_req_i     (per_req),
      .per_slave_i         (per_req_s),
      .per_slave_id_i      (per_id),
      .per_slave_gnt_o     (per_gnt),
      .per_slave_r_valid_o (resp_valid),
      .per_slave_r_o       (resp),
      .per_slave_r_id_o    (resp_id),
      .axi_axuser_i        (user_tab),
      .aw_valid_o          (aw_valid),
      .aw_o                (aw),
      .aw_id_o             (aw_id),
      .aw_user_o           (aw_user),
      .aw_ready_i          (aw_ready),
      .w_valid_o           (w_valid),
      .w_o                 (w),
      .w_ready_i           (w_ready),
      .ar_valid_o          (ar_valid),
      .ar_o                (ar),
      .ar_id_o             (ar_id),
      .ar_user_o           (ar_user),
      .ar_ready_i          (ar_ready),
      .r_valid_i           (r_valid),
      .r_data_i            (r_data),
      .r_id_i              (r_id),
      .r_ready_o           (r_ready),
      .b_valid_i           (b_valid),
      .b_id_i              (b_id),
      .b_ready_o           (b_ready),
      .busy_o              (busy)
   );

   task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
      assert (got === exp) else begin
         value_errs++;
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic expect_true(bit ok, string what);
      assert (ok) else begin
         proto_errs++;
         $display("at %0t ns: %s", $time, what);
      end
   endtask

   // ******************************
   // Request side checks
   // ******************************
   task automatic check_request();
      logic [8:0]          am;
      logic [2:0]          bid;
      logic [5:0]          usr;
      per2axi_pkg::axi_w_t wexp;
      bit                  is_wr;
      bit                  take;
      bit                  rd;
      am    = ref_atop(per_req_s.atop);
      bid   = ref_bin_id(per_id);
      usr   = (bid < 3'(NB_CORES)) ? user_tab[bid[1:0]] : 6'h0;
      is_wr = !per_req_s.we;
      rd    = !is_wr || returns_data(am[5:0]);
      // A write also needs w_ready before any beat goes out
      take  = per_req && aw_ready && ar_ready && (!is_wr || w_ready);
      compare_value("per_slave_gnt_o", per_gnt, aw_ready & ar_ready);
      compare_value("aw_valid_o", aw_valid, take && is_wr);
      compare_value("w_valid_o", w_valid, take && is_wr);
      compare_value("ar_valid_o", ar_valid, take && !is_wr);
      if (take && is_wr) begin
         wexp = ref_wbeat(per_req_s.add, per_req_s.wdata, per_req_s.be, am[8]);
         compare_value("aw_o.addr", aw.addr, per_req_s.add);
         compare_value("aw_o.size", aw.size, ref_size(per_req_s.be));
         compare_value("aw_o.lock", aw.lock, am[6]);
         compare_value("aw_o.atop", aw.atop, am[5:0]);
         compare_value("aw_id_o", aw_id, bid);
         compare_value("aw_user_o", aw_user, usr);
         compare_value("w_o.data", w.data, wexp.data);
         compare_value("w_o.strb", w.strb, wexp.strb);
         compare_value("w_o.last", w.last, wexp.last);
         queue_write_resp(bid);
         if (rd) begin
            queue_read_beat(bid, slave_rdata(per_req_s.add));
         end
      end else if (take) begin
         compare_value("ar_o.addr", ar.addr, per_req_s.add);
         compare_value("ar_o.size", ar.size, ref_size(per_req_s.be));
         compare_value("ar_o.lock", ar.lock, am[7]);
         compare_value("ar_o.atop", ar.atop, 6'h0);
         compare_value("ar_id_o", ar_id, bid);
         compare_value("ar_user_o", ar_user, usr);
         queue_read_beat(bid, slave_rdata(per_req_s.add));
      end
      if (take) begin
         issued++;
         outstanding++;
         resp_left[bid]  = 1'b1;
         is_atop_rd[bid] = is_wr && rd;
         beats_left[bid] = (is_wr && rd) ? 2 : 1;
         resp_due[bid]   = -1;
         exp_rdata[bid]  = rd ? lane_of(slave_rdata(per_req_s.add), per_req_s.add) : 32'h0;
      end
      req_pending = per_req && !take;
   endtask

   // ******************************
   // Slave model and responses
   // ******************************
   task automatic collect_slave_beats();
      slave_beat_t bt;
      compare_value("r_ready_o", r_ready, 1'b1);
      compare_value("b_ready_o", b_ready, !r_valid);
      // Beats taken at the last posedge answer in the cycle that follows it
      if (b_valid && b_ready) begin
         bt      = b_q.pop_front();
         b_valid = 1'b0;
         beats_left[bt.id]--;
         if (!is_atop_rd[bt.id]) begin
            resp_due[bt.id] = cycle;
         end
      end
      if (r_valid) begin
         bt      = r_q.pop_front();
         r_valid = 1'b0;
         beats_left[bt.id]--;
         resp_due[bt.id] = cycle;
      end
   endtask

   task automatic check_response();
      logic [2:0] b;
      if (!resp_valid) begin
         return;
      end
      b = ref_bin_id(resp_id);
      expect_true($onehot(resp_id), "per_slave_r_id_o is not one-hot");
      expect_true(resp_left[b], "response pulse for an ID with nothing outstanding");
      if (resp_left[b]) begin
         compare_value("per_slave_r_o.rdata", resp.rdata, exp_rdata[b]);
         compare_value("per_slave_r_o.opc", resp.opc, 1'b0);
         expect_true(resp_due[b] == cycle, "response pulse not one cycle after its beat");
         resp_left[b] = 1'b0;
         outstanding--;
         done_cnt++;
      end
   endtask

   task automatic drive_slave();
      if (!r_valid && r_q.size() > 0) begin
         if (int'(r_q[0].due) <= cycle && lcg_next() % 4 != 0) begin
            r_valid = 1'b1;
            r_id    = r_q[0].id;
            r_data  = r_q[0].data;
         end
      end
      if (!b_valid && b_q.size() > 0) begin
         if (int'(b_q[0].due) <= cycle && lcg_next() % 4 != 0) begin
            b_valid = 1'b1;
            b_id    = b_q[0].id;
         end
      end
   endtask

   task automatic drive_request();
      logic [2:0] b;
      logic [4:0] code;
      aw_ready = (lcg_next() % 4) != 0;
      w_ready  = (lcg_next() % 4) != 0;
      ar_ready = (lcg_next() % 4) != 0;
      // Core holds an ungranted request
      if (req_pending) begin
         return;
      end
      per_req = 1'b0;
      if (issued >= NUM_TRANS || (lcg_next() % 3) == 0) begin
         return;
      end
      b = 3'(lcg_next() % 5);
      if (resp_left[b] || beats_left[b] != 0) begin
         return;
      end
      // Extra lower ID bits, the highest one must win
      per_id          = 5'(32'd1 << b) | 5'(lcg_next() & ((32'd1 << b) - 1));
      per_req_s.add   = lcg_next();
      per_req_s.wdata = lcg_next();
      per_req_s.be    = 4'(lcg_next());
      per_req_s.we    = 1'(lcg_next());
      per_req_s.atop  = 6'h0;
      if (lcg_next() % 2 == 0) begin
         case (lcg_next() % 12)
            0:       code = per2axi_pkg::AMO_LR;
            1:       code = per2axi_pkg::AMO_SC;
            2:       code = per2axi_pkg::AMO_SWAP;
            3:       code = per2axi_pkg::AMO_ADD;
            4:       code = per2axi_pkg::AMO_XOR;
            5:       code = per2axi_pkg::AMO_AND;
            6:       code = per2axi_pkg::AMO_OR;
            7:       code = per2axi_pkg::AMO_MIN;
            8:       code = per2axi_pkg::AMO_MAX;
            9:       code = per2axi_pkg::AMO_MINU;
            10:      code = per2axi_pkg::AMO_MAXU;
            default: code = 5'(lcg_next());
         endcase
         per_req_s.atop = {1'b1, code};
         per_req_s.we   = (code == per2axi_pkg::AMO_LR);
      end
      per_req = 1'b1;
   endtask

   // Check what the last posedge did, then drive the next cycle
   always @(negedge clk) begin
      if (run) begin
         cycle++;
         check_request();
         collect_slave_beats();
         check_response();
         compare_value("busy_o", busy, outstanding != 0);
         drive_slave();
         drive_request();
      end
   end

   // ******************************
   // Reset, run and report
   // ******************************
   initial begin
      int waited;
      rst_n     = 1'b0;
      per_req   = 1'b0;
      per_req_s = '0;
      per_id    = '0;
      aw_ready  = 1'b0;
      w_ready   = 1'b0;
      ar_ready  = 1'b0;
      r_valid   = 1'b0;
      r_data    = '0;
      r_id      = '0;
      b_valid   = 1'b0;
      b_id      = '0;
      for (int c = 0; c < NB_CORES; c++) begin
         user_tab[c] = 6'(lcg_next());
      end
      for (int i = 0; i < 8; i++) begin
         beats_left[i] = 0;
         resp_due[i]   = -1;
         exp_rdata[i]  = '0;
      end
      repeat (16) @(negedge clk);
      compare_value("busy_o", busy, 1'b0);
      compare_value("per_slave_r_valid_o", resp_valid, 1'b0);
      rst_n = 1'b1;
      @(posedge clk);
      run    = 1'b1;
      waited = 0;
      while (done_cnt < NUM_TRANS && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (done_cnt < NUM_TRANS) begin
         timeouts++;
         $display("timeout: only %0d of %0d transactions completed", done_cnt, NUM_TRANS);
      end
      waited = 0;
      while (busy !== 1'b0 && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      if (busy !== 1'b0) begin
         timeouts++;
         $display("timeout: busy_o still high after all responses");
      end
      $display("errors: %0d value, %0d protocol, %0d timeout",
               value_errs, proto_errs, timeouts);
      if (value_errs + proto_errs + timeouts == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/per2axi.sv ====
/*
 * Interconnect to AXI4 bridge top level
 * Request channel, response channel and busy unit
 */

`timescale 1ns/1ps
`default_nettype none

module per2axi #(
   parameter int NB_CORES       = 4,
   parameter int PER_ID_WIDTH   = 5,
   parameter int AXI_ID_WIDTH   = 3,
   parameter int AXI_USER_WIDTH = 6
) (
   input  wire logic                                   clk_i,
   input  wire logic                                   rst_n_i,

   // Interconnect slave
   input  wire logic                                   per_slave_req_i,
   input  wire per2axi_pkg::per_req_t                  per_slave_i,
   input  wire logic [PER_ID_WIDTH-1:0]                per_slave_id_i,
   output logic                                        per_slave_gnt_o,
   output logic                                        per_slave_r_valid_o,
   output per2axi_pkg::per_resp_t                      per_slave_r_o,
   output logic [PER_ID_WIDTH-1:0]                     per_slave_r_id_o,
   input  wire logic [NB_CORES-1:0][AXI_USER_WIDTH-1:0] axi_axuser_i,

   // AXI4 master
   output logic                                        aw_valid_o,
   output per2axi_pkg::axi_ax_t                        aw_o,
   output logic [AXI_ID_WIDTH-1:0]                     aw_id_o,
   output logic [AXI_USER_WIDTH-1:0]                   aw_user_o,
   input  wire logic                                   aw_ready_i,
   output logic                                        w_valid_o,
   output per2axi_pkg::axi_w_t                         w_o,
   input  wire logic                                   w_ready_i,
   output logic                                        ar_valid_o,
   output per2axi_pkg::axi_ax_t                        ar_o,
   output logic [AXI_ID_WIDTH-1:0]                     ar_id_o,
   output logic [AXI_USER_WIDTH-1:0]                   ar_user_o,
   input  wire logic                                   ar_ready_i,
   input  wire logic                                   r_valid_i,
   input  wire logic [63:0]                            r_data_i,
   input  wire logic [AXI_ID_WIDTH-1:0]                r_id_i,
   output logic                                        r_ready_o,
   input  wire logic                                   b_valid_i,
   input  wire logic [AXI_ID_WIDTH-1:0]                b_id_i,
   output logic                                        b_ready_o,

   output logic                                        busy_o
);

   logic                    trans_req;
   logic [AXI_ID_WIDTH-1:0] trans_id;
   logic [31:0]             trans_add;
   logic                    atop_req;
   logic [AXI_ID_WIDTH-1:0] atop_id;
   logic [31:0]             atop_add;
   logic                    resp_fire;

   per2axi_req_channel #(
      .NB_CORES       (NB_CORES),
      .PER_ID_WIDTH   (PER_ID_WIDTH),
      .AXI_ID_WIDTH   (AXI_ID_WIDTH),
      .AXI_USER_WIDTH (AXI_USER_WIDTH)
   ) req_channel_inst (
      .per_slave_req_i (per_slave_req_i),
      .per_slave_i     (per_slave_i),
      .per_slave_id_i  (per_slave_id_i),
      .per_slave_gnt_o (per_slave_gnt_o),
      .axi_axuser_i    (axi_axuser_i),
      .aw_ready_i      (aw_ready_i),
      .w_ready_i       (w_ready_i),
      .ar_ready_i      (ar_ready_i),
      .aw_valid_o      (aw_valid_o),
      .aw_o            (aw_o),
      .aw_id_o         (aw_id_o),
      .aw_user_o       (aw_user_o),
      .w_valid_o       (w_valid_o),
      .w_o             (w_o),
      .ar_valid_o      (ar_valid_o),
      .ar_o            (ar_o),
      .ar_id_o         (ar_id_o),
      .ar_user_o       (ar_user_o),
      .trans_req_o     (trans_req),
      .trans_id_o      (trans_id),
      .trans_add_o     (trans_add),
      .atop_req_o      (atop_req),
      .atop_id_o       (atop_id),
      .atop_add_o      (atop_add)
   );

   per2axi_res_channel #(
      .PER_ID_WIDTH (PER_ID_WIDTH),
      .AXI_ID_WIDTH (AXI_ID_WIDTH)
   ) res_channel_inst (
      .clk_i               (clk_i),
      .rst_n_i             (rst_n_i),
      .r_valid_i           (r_valid_i),
      .r_data_i            (r_data_i),
      .r_id_i              (r_id_i),
      .r_ready_o           (r_ready_o),
      .b_valid_i           (b_valid_i),
      .b_id_i              (b_id_i),
      .b_ready_o           (b_ready_o),
      .trans_req_i         (trans_req),
      .trans_id_i          (trans_id),
      .trans_add_i         (trans_add),
      .atop_req_i          (atop_req),
      .atop_id_i           (atop_id),
      .atop_add_i          (atop_add),
      .per_slave_r_valid_o (per_slave_r_valid_o),
      .per_slave_r_o       (per_slave_r_o),
      .per_slave_r_id_o    (per_slave_r_id_o),
      .resp_fire_o         (resp_fire)
   );

   // Valid is only raised with its ready high, so valid is the handshake
   per2axi_busy_unit #(
      .AXI_ID_WIDTH (AXI_ID_WIDTH)
   ) busy_unit_inst (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .aw_fire_i   (aw_valid_o),
      .ar_fire_i   (ar_valid_o),
      .resp_fire_i (resp_fire),
      .busy_o      (busy_o)
   );

endmodule

`default_nettype wire

// ==== hdl/per2axi_busy_unit.sv ====
/*
 * Busy unit, counts outstanding AXI transactions
 */

`timescale 1ns/1ps
`default_nettype none

module per2axi_busy_unit #(
   parameter int AXI_ID_WIDTH = 3
) (
   input  wire logic clk_i,
   input  wire logic rst_n_i,
   input  wire logic aw_fire_i,
   input  wire logic ar_fire_i,
   input  wire logic resp_fire_i,
   output logic      busy_o
);

   // At most one transaction per ID, one spare bit for headroom
   logic [AXI_ID_WIDTH:0] cnt_q;
   logic [AXI_ID_WIDTH:0] cnt_d;
   logic                  inc;

   assign inc = aw_fire_i | ar_fire_i;

   always_comb begin
      cnt_d = cnt_q;
      case ({inc, resp_fire_i})
         2'b10:   cnt_d = cnt_q + 1'b1;
         2'b01:   cnt_d = cnt_q - 1'b1;
         default: cnt_d = cnt_q;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q  <= '0;
         busy_o <= 1'b0;
      end else begin
         cnt_q  <= cnt_d;
         busy_o <= (cnt_d != '0);
      end
   end

   // A response always belongs to an earlier address beat
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (resp_fire_i && !inc) |-> (cnt_q != '0));

endmodule

`default_nettype wire

// ==== hdl/per2axi_res_channel.sv ====
/*
 * Response channel of the bridge
 * Turns R and B beats into registered interconnect responses
 */

`timescale 1ns/1ps
`default_nettype none

module per2axi_res_channel #(
   parameter int PER_ID_WIDTH = 5,
   parameter int AXI_ID_WIDTH = 3
) (
   input  wire logic                    clk_i,
   input  wire logic                    rst_n_i,

   // AXI read data and write response
   input  wire logic                    r_valid_i,
   input  wire logic [63:0]             r_data_i,
   input  wire logic [AXI_ID_WIDTH-1:0] r_id_i,
   output logic                         r_ready_o,
   input  wire logic                    b_valid_i,
   input  wire logic [AXI_ID_WIDTH-1:0] b_id_i,
   output logic                         b_ready_o,

   // Lane bookkeeping from the request channel
   input  wire logic                    trans_req_i,
   input  wire logic [AXI_ID_WIDTH-1:0] trans_id_i,
   input  wire logic [31:0]             trans_add_i,
   input  wire logic                    atop_req_i,
   input  wire logic [AXI_ID_WIDTH-1:0] atop_id_i,
   input  wire logic [31:0]             atop_add_i,

   // Interconnect response
   output logic                         per_slave_r_valid_o,
   output per2axi_pkg::per_resp_t       per_slave_r_o,
   output logic [PER_ID_WIDTH-1:0]      per_slave_r_id_o,
   output logic                         resp_fire_o
);

   localparam int NB_IDS = 2 ** AXI_ID_WIDTH;

   // Per ID: upper lane bit and atomic with data pending
   logic [NB_IDS-1:0] lane_q;
   logic [NB_IDS-1:0] atop_pend_q;
   logic              r_fire;
   logic              b_fire;
   logic              b_resp;

   // Read data always wins over the write response
   assign r_ready_o = 1'b1;
   assign b_ready_o = ~r_valid_i;

   assign r_fire      = r_valid_i & r_ready_o;
   assign b_fire      = b_valid_i & b_ready_o;
   assign b_resp      = b_fire & ~atop_pend_q[b_id_i];
   assign resp_fire_o = r_fire | b_resp;

   // Flag drops with the absorbed B, so R and B may come in either order
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lane_q      <= '0;
         atop_pend_q <= '0;
      end else begin
         if (b_fire) begin
            atop_pend_q[b_id_i] <= 1'b0;
         end
         if (trans_req_i) begin
            lane_q[trans_id_i] <= trans_add_i[2];
         end
         if (atop_req_i) begin
            lane_q[atop_id_i]      <= atop_add_i[2];
            atop_pend_q[atop_id_i] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         per_slave_r_valid_o <= 1'b0;
      end else begin
         per_slave_r_valid_o <= resp_fire_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_fire) begin
         per_slave_r_o    <= '{rdata: lane_q[r_id_i] ? r_data_i[63:32] : r_data_i[31:0],
                               opc: 1'b0};
         per_slave_r_id_o <= PER_ID_WIDTH'(1) << r_id_i;
      end else if (b_resp) begin
         per_slave_r_o    <= '{rdata: 32'h0, opc: 1'b0};
         per_slave_r_id_o <= PER_ID_WIDTH'(1) << b_id_i;
      end
   end

   // One transaction per ID, so no back-to-back pulse for one core
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      per_slave_r_valid_o |=>
         !(per_slave_r_valid_o && per_slave_r_id_o == $past(per_slave_r_id_o)));

endmodule

`default_nettype wire

// ==== hdl/per2axi_req_channel.sv ====
/*
 * Request channel of the bridge
 * Maps interconnect requests to AW, W and AR beats
 */

`timescale 1ns/1ps
`default_nettype none

module per2axi_req_channel #(
   parameter int NB_CORES       = 4,
   parameter int PER_ID_WIDTH   = 5,
   parameter int AXI_ID_WIDTH   = 3,
   parameter int AXI_USER_WIDTH = 6
) (
   // Interconnect request
   input  wire logic                                   per_slave_req_i,
   input  wire per2axi_pkg::per_req_t                  per_slave_i,
   input  wire logic [PER_ID_WIDTH-1:0]                per_slave_id_i,
   output logic                                        per_slave_gnt_o,
   input  wire logic [NB_CORES-1:0][AXI_USER_WIDTH-1:0] axi_axuser_i,

   // AXI ready levels
   input  wire logic                                   aw_ready_i,
   input  wire logic                                   w_ready_i,
   input  wire logic                                   ar_ready_i,

   // AXI beats
   output logic                                        aw_valid_o,
   output per2axi_pkg::axi_ax_t                        aw_o,
   output logic [AXI_ID_WIDTH-1:0]                     aw_id_o,
   output logic [AXI_USER_WIDTH-1:0]                   aw_user_o,
   output logic                                        w_valid_o,
   output per2axi_pkg::axi_w_t                         w_o,
   output logic                                        ar_valid_o,
   output per2axi_pkg::axi_ax_t                        ar_o,
   output logic [AXI_ID_WIDTH-1:0]                     ar_id_o,
   output logic [AXI_USER_WIDTH-1:0]                   ar_user_o,

   // Lane bookkeeping towards the response channel
   output logic                                        trans_req_o,
   output logic [AXI_ID_WIDTH-1:0]                     trans_id_o,
   output logic [31:0]                                 trans_add_o,
   output logic                                        atop_req_o,
   output logic [AXI_ID_WIDTH-1:0]                     atop_id_o,
   output logic [31:0]                                 atop_add_o
);

   logic [5:0]                awatop;
   logic                      aw_lock;
   logic                      ar_lock;
   logic                      inv_wdata;
   logic [31:0]               wdata;
   logic [2:0]                size;
   logic [AXI_ID_WIDTH-1:0]   bin_id;
   logic [AXI_USER_WIDTH-1:0] user;

   // ******************************
   // Grant and valid
   // ******************************
   assign per_slave_gnt_o = aw_ready_i & ar_ready_i;

   // Valid only with the grant, so no beat waits on a ready
   assign aw_valid_o = per_slave_req_i & ~per_slave_i.we & per_slave_gnt_o & w_ready_i;
   assign w_valid_o  = aw_valid_o;
   assign ar_valid_o = per_slave_req_i & per_slave_i.we & per_slave_gnt_o;

   // ******************************
   // Atomic mapping
   // ******************************
   always_comb begin
      awatop    = '0;
      aw_lock   = 1'b0;
      ar_lock   = 1'b0;
      inv_wdata = 1'b0;
      if (per_slave_i.atop[5]) begin
         case (per_slave_i.atop[4:0])
            per2axi_pkg::AMO_LR:   ar_lock = 1'b1;
            per2axi_pkg::AMO_SC:   aw_lock = 1'b1;
            per2axi_pkg::AMO_SWAP: awatop  = per2axi_pkg::ATOP_SWAP;
            per2axi_pkg::AMO_ADD:  awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_ADD};
            per2axi_pkg::AMO_XOR:  awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_XOR};
            per2axi_pkg::AMO_AND: begin
               // AND done as clear of the inverted operand
               awatop    = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_CLR};
               inv_wdata = 1'b1;
            end
            per2axi_pkg::AMO_OR:   awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_SET};
            per2axi_pkg::AMO_MIN:  awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_SMIN};
            per2axi_pkg::AMO_MAX:  awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_SMAX};
            per2axi_pkg::AMO_MINU: awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_UMIN};
            per2axi_pkg::AMO_MAXU: awatop  = {per2axi_pkg::ATOP_LOAD, per2axi_pkg::ATOP_UMAX};
            default: awatop = '0;
         endcase
      end
   end

   // ******************************
   // Data, size, ID and user
   // ******************************
   assign wdata = inv_wdata ? ~per_slave_i.wdata : per_slave_i.wdata;

   always_comb begin
      w_o.last = 1'b1;
      if (per_slave_i.add[2]) begin
         w_o.data = {wdata, 32'h0};
         w_o.strb = {per_slave_i.be, 4'h0};
      end else begin
         w_o.data = {32'h0, wdata};
         w_o.strb = {4'h0, per_slave_i.be};
      end
   end

   always_comb begin
      case (per_slave_i.be)
         4'b0011, 4'b0110, 4'b1100: size = 3'd1;
         4'b1111:                   size = 3'd2;
         default:                   size = 3'd0;
      endcase
   end

   // One-hot to binary, highest set bit wins
   always_comb begin
      bin_id = '0;
      for (int i = 0; i < PER_ID_WIDTH; i++) begin
         if (per_slave_id_i[i]) begin
            bin_id = AXI_ID_WIDTH'(i);
         end
      end
      user = '0;
      for (int c = 0; c < NB_CORES; c++) begin
         if (bin_id == AXI_ID_WIDTH'(c)) begin
            user = axi_axuser_i[c];
         end
      end
   end

   assign aw_o      = '{addr: per_slave_i.add, size: size, lock: aw_lock, atop: awatop};
   assign ar_o      = '{addr: per_slave_i.add, size: size, lock: ar_lock, atop: 6'h0};
   assign aw_id_o   = bin_id;
   assign ar_id_o   = bin_id;
   assign aw_user_o = user;
   assign ar_user_o = user;

   // Reads and data-returning atomics both need the lane later
   assign trans_req_o = ar_valid_o;
   assign trans_id_o  = bin_id;
   assign trans_add_o = per_slave_i.add;
   assign atop_req_o  = aw_valid_o & (|awatop) & (awatop[5:3] != per2axi_pkg::ATOP_STORE);
   assign atop_id_o   = bin_id;
   assign atop_add_o  = per_slave_i.add;

endmodule

`default_nettype wire

// ==== hdl/per2axi_pkg.sv ====
/*
 * Shared definitions for the interconnect to AXI4 bridge
 * RISC-V atomic codes, AXI atomic codes, request and beat structs
 */

`default_nettype none

package per2axi_pkg;

   // RISC-V A extension function codes, valid when atop[5] is set
   localparam logic [4:0] AMO_LR   = 5'b00010;
   localparam logic [4:0] AMO_SC   = 5'b00011;
   localparam logic [4:0] AMO_SWAP = 5'b00001;
   localparam logic [4:0] AMO_ADD  = 5'b00000;
   localparam logic [4:0] AMO_XOR  = 5'b00100;
   localparam logic [4:0] AMO_AND  = 5'b01100;
   localparam logic [4:0] AMO_OR   = 5'b01000;
   localparam logic [4:0] AMO_MIN  = 5'b10000;
   localparam logic [4:0] AMO_MAX  = 5'b10100;
   localparam logic [4:0] AMO_MINU = 5'b11000;
   localparam logic [4:0] AMO_MAXU = 5'b11100;

   // AXI atomic encodings
   localparam logic [5:0] ATOP_SWAP    = 6'b110000;
   localparam logic [5:0] ATOP_COMPARE = 6'b110001;

   localparam logic [2:0] ATOP_STORE = 3'b010;
   localparam logic [2:0] ATOP_LOAD  = 3'b100;

   localparam logic [2:0] ATOP_ADD  = 3'b000;
   localparam logic [2:0] ATOP_CLR  = 3'b001;
   localparam logic [2:0] ATOP_XOR  = 3'b010;
   localparam logic [2:0] ATOP_SET  = 3'b011;
   localparam logic [2:0] ATOP_SMAX = 3'b100;
   localparam logic [2:0] ATOP_SMIN = 3'b101;
   localparam logic [2:0] ATOP_UMAX = 3'b110;
   localparam logic [2:0] ATOP_UMIN = 3'b111;

   // Interconnect request, we low means write
   typedef struct packed {
      logic [31:0] add;
      logic        we;
      logic [5:0]  atop;
      logic [31:0] wdata;
      logic [3:0]  be;
   } per_req_t;

   // Address beat for both AW and AR
   typedef struct packed {
      logic [31:0] addr;
      logic [2:0]  size;
      logic        lock;
      logic [5:0]  atop;
   } axi_ax_t;

   typedef struct packed {
      logic [63:0] data;
      logic [7:0]  strb;
      logic        last;
   } axi_w_t;

   typedef struct packed {
      logic [31:0] rdata;
      logic        opc;
   } per_resp_t;

endpackage

`default_nettype wire
